// ==== logic/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// integer register and datapath width, fixed by RV64
`define EXEC_XLEN 64

// program counter and branch target width
`define EXEC_ADDR_W 64

// architectural register index, x0 to x31
`define EXEC_REG_W 5

`endif

// ==== logic/exec_pkg.sv ====
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`EXEC_XLEN-1:0] xdata_t;
	typedef logic [`EXEC_ADDR_W-1:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [`EXEC_REG_W-1:0] reg_idx_t;
	typedef logic [4:0] alu_op_t;

	// arithmetic
	localparam alu_op_t ALU_ADD = 5'd0;
	localparam alu_op_t ALU_ADDW = 5'd1;
	localparam alu_op_t ALU_SUB = 5'd17;
	localparam alu_op_t ALU_SUBW = 5'd18;

	// shifts, full width and word
	localparam alu_op_t ALU_SLL = 5'd2;
	localparam alu_op_t ALU_SLLW = 5'd3;
	localparam alu_op_t ALU_SRA = 5'd4;
	localparam alu_op_t ALU_SRAW = 5'd5;
	localparam alu_op_t ALU_SRL = 5'd6;
	localparam alu_op_t ALU_SRLW = 5'd7;

	// bitwise logic
	localparam alu_op_t ALU_AND = 5'd8;
	localparam alu_op_t ALU_OR = 5'd9;
	localparam alu_op_t ALU_XOR = 5'd10;

	// compares return 0 or 1
	localparam alu_op_t ALU_SLT = 5'd11;
	localparam alu_op_t ALU_SLTU = 5'd12;
	localparam alu_op_t ALU_EQ = 5'd13;
	localparam alu_op_t ALU_NE = 5'd14;
	localparam alu_op_t ALU_SGE = 5'd15;
	localparam alu_op_t ALU_SGEU = 5'd16;

	// major opcodes handled by this stage pair
	localparam logic [6:0] OPC_OP = 7'b011_0011;
	localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
	localparam logic [6:0] OPC_OP_32 = 7'b011_1011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b001_1011;
	localparam logic [6:0] OPC_LUI = 7'b011_0111;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

endpackage

`default_nettype wire

// ==== logic/alu_core.sv ====
`default_nettype none

`include "exec_settings.svh"

module alu_core (
	input exec_pkg::alu_op_t op,
	input exec_pkg::xdata_t src_a,
	input exec_pkg::xdata_t src_b,
	output exec_pkg::xdata_t result
);

	import exec_pkg::*;

	// full width shifts take six amount bits, word shifts five
	logic [5:0] shamt;
	logic [4:0] shamt_w;

	// 32-bit word results before sign extension
	logic [31:0] add_w;
	logic [31:0] sub_w;
	logic [31:0] sll_w;
	logic [31:0] srl_w;
	logic [31:0] sra_w;

	// word results take bit 31 as the sign
	function automatic xdata_t sext_word(input logic [31:0] w);
		sext_word = {{(`EXEC_XLEN-32){w[31]}}, w};
	endfunction

	assign shamt = src_b[5:0];
	assign shamt_w = src_b[4:0];

	assign add_w = src_a[31:0] + src_b[31:0];
	assign sub_w = src_a[31:0] - src_b[31:0];
	assign sll_w = src_a[31:0] << shamt_w;
	assign srl_w = src_a[31:0] >> shamt_w;
	assign sra_w = $signed(src_a[31:0]) >>> shamt_w;

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = src_a + src_b;
			end
			ALU_ADDW: begin
				result = sext_word(add_w);
			end
			ALU_SUB: begin
				result = src_a - src_b;
			end
			ALU_SUBW: begin
				result = sext_word(sub_w);
			end
			ALU_SLL: begin
				result = src_a << shamt;
			end
			ALU_SLLW: begin
				result = sext_word(sll_w);
			end
			ALU_SRA: begin
				result = $signed(src_a) >>> shamt;
			end
			ALU_SRAW: begin
				result = sext_word(sra_w);
			end
			ALU_SRL: begin
				result = src_a >> shamt;
			end
			ALU_SRLW: begin
				result = sext_word(srl_w);
			end
			ALU_AND: begin
				result = src_a & src_b;
			end
			ALU_OR: begin
				result = src_a | src_b;
			end
			ALU_XOR: begin
				result = src_a ^ src_b;
			end
			ALU_SLT: begin
				result = xdata_t'($signed(src_a) < $signed(src_b));
			end
			ALU_SLTU: begin
				result = xdata_t'(src_a < src_b);
			end
			ALU_EQ: begin
				result = xdata_t'(src_a == src_b);
			end
			ALU_NE: begin
				result = xdata_t'(src_a != src_b);
			end
			ALU_SGE: begin
				result = xdata_t'($signed(src_a) >= $signed(src_b));
			end
			ALU_SGEU: begin
				result = xdata_t'(src_a >= src_b);
			end
			// codes 19 and up are not implemented
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/issue_decode.sv ====
`default_nettype none

`include "exec_settings.svh"

module issue_decode (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input exec_pkg::addr_t in_pc,
	input exec_pkg::instr_t in_instr,
	input exec_pkg::xdata_t in_rs1_data,
	input exec_pkg::xdata_t in_rs2_data,
	output logic dec_valid,
	input logic dec_ready,
	output exec_pkg::addr_t dec_pc,
	output exec_pkg::instr_t dec_instr,
	output exec_pkg::reg_idx_t dec_rd,
	output logic dec_reg_we,
	output logic dec_is_branch,
	output exec_pkg::alu_op_t dec_alu_op,
	output exec_pkg::xdata_t dec_src_a,
	output exec_pkg::xdata_t dec_src_b,
	output exec_pkg::xdata_t dec_rs2_data,
	output exec_pkg::addr_t dec_branch_imm
);

	import exec_pkg::*;

	// instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	reg_idx_t rd;
	xdata_t imm_i;
	xdata_t imm_u;
	addr_t imm_b;

	// decoded values ahead of the stage register
	alu_op_t nxt_alu_op;
	xdata_t nxt_src_a;
	xdata_t nxt_src_b;
	logic nxt_writes;
	logic nxt_is_branch;

	// OP and OP-IMM share one funct3 map, only the register form subtracts
	function automatic alu_op_t full_op(input logic [2:0] f3, input logic sel_alt,
			input logic reg_form);
		case (f3)
			3'b000: full_op = (sel_alt && reg_form) ? ALU_SUB : ALU_ADD;
			3'b001: full_op = ALU_SLL;
			3'b010: full_op = ALU_SLT;
			3'b011: full_op = ALU_SLTU;
			3'b100: full_op = ALU_XOR;
			3'b101: full_op = sel_alt ? ALU_SRA : ALU_SRL;
			3'b110: full_op = ALU_OR;
			default: full_op = ALU_AND;
		endcase
	endfunction

	// word forms only define add, sub and the three shifts
	function automatic alu_op_t word_op(input logic [2:0] f3, input logic sel_alt,
			input logic reg_form);
		case (f3)
			3'b001: word_op = ALU_SLLW;
			3'b101: word_op = sel_alt ? ALU_SRAW : ALU_SRLW;
			default: word_op = (sel_alt && reg_form) ? ALU_SUBW : ALU_ADDW;
		endcase
	endfunction

	assign opcode = in_instr[6:0];
	assign funct3 = in_instr[14:12];
	assign alt = in_instr[30];
	assign rd = in_instr[11:7];

	assign imm_i = {{(`EXEC_XLEN-12){in_instr[31]}}, in_instr[31:20]};
	assign imm_u = {{(`EXEC_XLEN-32){in_instr[31]}}, in_instr[31:12], 12'b0};
	assign imm_b = {{(`EXEC_ADDR_W-13){in_instr[31]}}, in_instr[31], in_instr[7],
		in_instr[30:25], in_instr[11:8], 1'b0};

	always_comb begin
		// unsupported encodings fall through as add of zeros, no write
		nxt_alu_op = ALU_ADD;
		nxt_src_a = '0;
		nxt_src_b = '0;
		nxt_writes = 1'b0;
		nxt_is_branch = 1'b0;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				nxt_src_a = in_rs1_data;
				nxt_src_b = (opcode == OPC_OP) ? in_rs2_data : imm_i;
				nxt_alu_op = full_op(funct3, alt, opcode == OPC_OP);
				nxt_writes = 1'b1;
			end
			OPC_OP_32, OPC_OP_IMM_32: begin
				if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) begin
					nxt_src_a = in_rs1_data;
					nxt_src_b = (opcode == OPC_OP_32) ? in_rs2_data : imm_i;
					nxt_alu_op = word_op(funct3, alt, opcode == OPC_OP_32);
					nxt_writes = 1'b1;
				end
			end
			OPC_LUI: begin
				nxt_src_b = imm_u;
				nxt_writes = 1'b1;
			end
			OPC_BRANCH: begin
				// rs2 is compared in execute, src_b stays zero
				nxt_src_a = in_rs1_data;
				nxt_is_branch = 1'b1;
				case (funct3)
					3'b000: nxt_alu_op = ALU_EQ;
					3'b001: nxt_alu_op = ALU_NE;
					3'b100: nxt_alu_op = ALU_SLT;
					3'b101: nxt_alu_op = ALU_SGE;
					3'b110: nxt_alu_op = ALU_SLTU;
					3'b111: nxt_alu_op = ALU_SGEU;
					default: nxt_is_branch = 1'b0;
				endcase
			end
			default: begin
				nxt_writes = 1'b0;
			end
		endcase
	end

	// take a new item when empty or when the current one leaves
	assign in_ready = !dec_valid || dec_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_reg_we <= 1'b0;
			dec_is_branch <= 1'b0;
			dec_alu_op <= '0;
		end else if (in_ready) begin
			dec_valid <= in_valid;
			if (in_valid) begin
				dec_reg_we <= nxt_writes && (rd != '0);
				dec_is_branch <= nxt_is_branch;
				dec_alu_op <= nxt_alu_op;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dec_pc <= in_pc;
			dec_instr <= in_instr;
			dec_rd <= rd;
			dec_src_a <= nxt_src_a;
			dec_src_b <= nxt_src_b;
			dec_rs2_data <= in_rs2_data;
			dec_branch_imm <= imm_b;
		end
	end

	// execute may stall us, the held item must not change
	a_dec_hold: assert property (@(posedge clk) disable iff (reset)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_instr)
		&& $stable(dec_rd) && $stable(dec_reg_we) && $stable(dec_is_branch)
		&& $stable(dec_alu_op) && $stable(dec_src_a) && $stable(dec_src_b)
		&& $stable(dec_rs2_data) && $stable(dec_branch_imm));

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input logic clk,
	input logic reset,
	input logic dec_valid,
	output logic dec_ready,
	input exec_pkg::addr_t dec_pc,
	input exec_pkg::instr_t dec_instr,
	input exec_pkg::reg_idx_t dec_rd,
	input logic dec_reg_we,
	input logic dec_is_branch,
	input exec_pkg::alu_op_t dec_alu_op,
	input exec_pkg::xdata_t dec_src_a,
	input exec_pkg::xdata_t dec_src_b,
	input exec_pkg::xdata_t dec_rs2_data,
	input exec_pkg::addr_t dec_branch_imm,
	output logic out_valid,
	input logic out_ready,
	output exec_pkg::addr_t out_pc,
	output exec_pkg::instr_t out_instr,
	output exec_pkg::reg_idx_t out_rd,
	output logic out_reg_we,
	output exec_pkg::xdata_t out_result,
	output logic out_branch_taken,
	output exec_pkg::addr_t out_branch_target
);

	import exec_pkg::*;

	xdata_t alu_b;
	xdata_t alu_result;
	logic taken;
	addr_t target;

	// branches compare rs1 against rs2
	assign alu_b = dec_is_branch ? dec_rs2_data : dec_src_b;

	alu_core u_alu (
		.op(dec_alu_op),
		.src_a(dec_src_a),
		.src_b(alu_b),
		.result(alu_result)
	);

	// compare result is 0 or 1, bit 0 is the condition
	assign taken = dec_is_branch && alu_result[0];
	assign target = dec_pc + dec_branch_imm;

	assign dec_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_reg_we <= 1'b0;
			out_branch_taken <= 1'b0;
		end else if (dec_ready) begin
			out_valid <= dec_valid;
			if (dec_valid) begin
				out_reg_we <= dec_reg_we && !dec_is_branch;
				out_branch_taken <= taken;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid && dec_ready) begin
			out_pc <= dec_pc;
			out_instr <= dec_instr;
			out_rd <= dec_rd;
			out_result <= dec_is_branch ? '0 : alu_result;
			out_branch_target <= target;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_instr)
		&& $stable(out_rd) && $stable(out_reg_we) && $stable(out_result)
		&& $stable(out_branch_taken) && $stable(out_branch_target));

	// a branch never writes a register
	a_we_or_taken: assert property (@(posedge clk) disable iff (reset)
		!(out_reg_we && out_branch_taken));

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`default_nettype none

module exec_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input exec_pkg::addr_t in_pc,
	input exec_pkg::instr_t in_instr,
	input exec_pkg::xdata_t in_rs1_data,
	input exec_pkg::xdata_t in_rs2_data,
	output logic out_valid,
	input logic out_ready,
	output exec_pkg::addr_t out_pc,
	output exec_pkg::instr_t out_instr,
	output exec_pkg::reg_idx_t out_rd,
	output logic out_reg_we,
	output exec_pkg::xdata_t out_result,
	output logic out_branch_taken,
	output exec_pkg::addr_t out_branch_target
);

	import exec_pkg::*;

	// decode to execute
	logic dec_valid;
	logic dec_ready;
	addr_t dec_pc;
	instr_t dec_instr;
	reg_idx_t dec_rd;
	logic dec_reg_we;
	logic dec_is_branch;
	alu_op_t dec_alu_op;
	xdata_t dec_src_a;
	xdata_t dec_src_b;
	xdata_t dec_rs2_data;
	addr_t dec_branch_imm;

	issue_decode u_decode (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_instr(in_instr),
		.in_rs1_data(in_rs1_data),
		.in_rs2_data(in_rs2_data),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_pc(dec_pc),
		.dec_instr(dec_instr),
		.dec_rd(dec_rd),
		.dec_reg_we(dec_reg_we),
		.dec_is_branch(dec_is_branch),
		.dec_alu_op(dec_alu_op),
		.dec_src_a(dec_src_a),
		.dec_src_b(dec_src_b),
		.dec_rs2_data(dec_rs2_data),
		.dec_branch_imm(dec_branch_imm)
	);

	execute_stage u_execute (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_pc(dec_pc),
		.dec_instr(dec_instr),
		.dec_rd(dec_rd),
		.dec_reg_we(dec_reg_we),
		.dec_is_branch(dec_is_branch),
		.dec_alu_op(dec_alu_op),
		.dec_src_a(dec_src_a),
		.dec_src_b(dec_src_b),
		.dec_rs2_data(dec_rs2_data),
		.dec_branch_imm(dec_branch_imm),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pc(out_pc),
		.out_instr(out_instr),
		.out_rd(out_rd),
		.out_reg_we(out_reg_we),
		.out_result(out_result),
		.out_branch_taken(out_branch_taken),
		.out_branch_target(out_branch_target)
	);

endmodule

`default_nettype wire

// ==== test/exec_tb.sv ====
`default_nettype none

`include "exec_settings.svh"

module exec_tb;

	import exec_pkg::*;

	localparam int CYCLE_LIMIT = 3000;
	localparam int ITEMS_PER_TEST = 120;
	localparam int DRAIN_LIMIT = 64;

	typedef struct packed {
		addr_t pc;
		instr_t instr;
		reg_idx_t rd;
		logic we;
		xdata_t result;
		logic taken;
		addr_t target;
	} expect_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic in_valid, in_ready, out_valid, out_ready;
	addr_t in_pc, out_pc, out_branch_target;
	instr_t in_instr, out_instr;
	xdata_t in_rs1_data, in_rs2_data, out_result;
	reg_idx_t out_rd;
	logic out_reg_we, out_branch_taken;

	expect_t exp_q[$];
	expect_t head;
	logic head_valid = 1'b0;
	logic in_take = 1'b0;
	logic out_take = 1'b0;
	logic [31:0] rng = 32'h86b271b7;
	int errors = 0;
	int checked = 0;
	int cycles = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	exec_top u_dut (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic xdata_t sext32(input logic [31:0] w);
		return {{(`EXEC_XLEN-32){w[31]}}, w};
	endfunction

	// reference model of decode plus ALU from the ISA rules
	function automatic expect_t predict(input addr_t pc, input instr_t ins,
			input xdata_t a, input xdata_t rs2);
		expect_t e;
		xdata_t b;
		logic [2:0] f3;
		logic is_reg;
		f3 = ins[14:12];
		is_reg = (ins[6:0] == OPC_OP) || (ins[6:0] == OPC_OP_32);
		b = is_reg ? rs2 : {{(`EXEC_XLEN-12){ins[31]}}, ins[31:20]};
		e.pc = pc;
		e.instr = ins;
		e.rd = ins[11:7];
		e.we = 1'b0;
		e.result = '0;
		e.taken = 1'b0;
		e.target = pc + {{(`EXEC_ADDR_W-13){ins[31]}}, ins[31], ins[7], ins[30:25],
			ins[11:8], 1'b0};
		case (ins[6:0])
			OPC_OP, OPC_OP_IMM: begin
				e.we = 1'b1;
				case (f3)
					3'd0: e.result = (is_reg && ins[30]) ? a - b : a + b;
					3'd1: e.result = a << b[5:0];
					3'd2: e.result = {63'b0, $signed(a) < $signed(b)};
					3'd3: e.result = {63'b0, a < b};
					3'd4: e.result = a ^ b;
					3'd5: e.result = ins[30] ? xdata_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
					3'd6: e.result = a | b;
					default: e.result = a & b;
				endcase
			end
			OPC_OP_32, OPC_OP_IMM_32: begin
				e.we = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
				if (f3 == 3'd0)
					e.result = sext32((is_reg && ins[30]) ? a[31:0] - b[31:0]
						: a[31:0] + b[31:0]);
				else if (f3 == 3'd1)
					e.result = sext32(a[31:0] << b[4:0]);
				else if (f3 == 3'd5)
					e.result = sext32(ins[30] ? 32'($signed(a[31:0]) >>> b[4:0])
						: a[31:0] >> b[4:0]);
			end
			OPC_LUI: begin
				e.we = 1'b1;
				e.result = sext32({ins[31:12], 12'b0});
			end
			OPC_BRANCH: begin
				case (f3)
					3'd0: e.taken = a == rs2;
					3'd1: e.taken = a != rs2;
					3'd4: e.taken = $signed(a) < $signed(rs2);
					3'd5: e.taken = $signed(a) >= $signed(rs2);
					3'd6: e.taken = a < rs2;
					default: e.taken = a >= rs2;
				endcase
			end
			default: begin
				e.we = 1'b0;
			end
		endcase
		e.we = e.we && (e.rd != '0);
		return e;
	endfunction

	// one random instruction of the class picked by the test
	function automatic instr_t make_instr(input int test_id);
		instr_t ins;
		int cls;
		logic [2:0] pick;
		ins = next_rand();
		pick = 3'(next_rand());
		case (test_id)
			0: cls = 0;
			1: cls = 2 + int'(pick[0]);
			2: cls = (pick < 3'd5) ? 1 : 4;
			3: cls = 5;
			default: cls = int'(next_rand() % 7);
		endcase
		case (cls)
			0: ins[6:0] = OPC_OP;
			1: ins[6:0] = OPC_OP_IMM;
			2, 3: begin
				ins[6:0] = (cls == 2) ? OPC_OP_32 : OPC_OP_IMM_32;
				ins[14:12] = (pick < 3'd3) ? 3'd0 : ((pick < 3'd5) ? 3'd1 : 3'd5);
			end
			4: ins[6:0] = OPC_LUI;
			5: begin
				ins[6:0] = OPC_BRANCH;
				if (ins[14:13] == 2'b01)
					ins[14] = 1'b1;
			end
			default: ins[6:0] = pick[0] ? 7'b000_0011 : 7'b110_1111;
		endcase
		if (pick == 3'd7)
			ins[11:7] = '0;
		return ins;
	endfunction

	task automatic report_mismatch(input string name, input xdata_t exp_v, input xdata_t act_v);
		$display("FAIL %s expected %h actual %h", name, exp_v, act_v);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error: %s", what);
		errors++;
	endtask

	// transfers are decided at the falling edge where all handshake signals are settled
	always @(negedge clk) begin
		if (reset) begin
			in_take = 1'b0;
			out_take = 1'b0;
		end else begin
			if (out_take) begin
				if (exp_q.size() > 0)
					exp_q.delete(0);
				checked++;
			end
			head_valid = exp_q.size() > 0;
			if (head_valid)
				head = exp_q[0];
			in_take = in_valid && in_ready;
			if (in_take)
				exp_q.push_back(predict(in_pc, in_instr, in_rs1_data, in_rs2_data));
			out_take = out_valid && out_ready;
		end
	end

	chk_expected: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> head_valid)
		else report_problem("output transfer with no item outstanding");
	chk_pc: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_pc == head.pc)
		else report_mismatch("out_pc", head.pc, $sampled(out_pc));
	chk_instr: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_instr == head.instr)
		else report_mismatch("out_instr", 64'(head.instr), 64'($sampled(out_instr)));
	chk_rd: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_rd == head.rd)
		else report_mismatch("out_rd", 64'(head.rd), 64'($sampled(out_rd)));
	chk_we: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_reg_we == head.we)
		else report_mismatch("out_reg_we", 64'(head.we), 64'($sampled(out_reg_we)));
	chk_result: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_result == head.result)
		else report_mismatch("out_result", head.result, $sampled(out_result));
	chk_taken: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_branch_taken == head.taken)
		else report_mismatch("out_branch_taken", 64'(head.taken), 64'($sampled(out_branch_taken)));
	chk_target: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> out_branch_target == head.target)
		else report_mismatch("out_branch_target", head.target, $sampled(out_branch_target));
	chk_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_pc)
		&& $stable(out_instr) && $stable(out_branch_target) && $stable(out_rd)
		&& $stable(out_reg_we) && $stable(out_branch_taken))
		else report_problem("output changed or dropped while stalled");
	chk_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else report_problem("out_valid high just after reset");

	always @(posedge clk) begin
		out_ready <= reset ? 1'b1 : (next_rand() % 4 != 0);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d items still outstanding", cycles, exp_q.size());
			$display("Checks failed");
			$finish;
		end
	end

	task automatic run_test(input int test_id, input string name);
		int sent;
		int errors_before;
		int waited;
		xdata_t rs1;
		sent = 0;
		errors_before = errors;
		while (sent < ITEMS_PER_TEST) begin
			@(posedge clk);
			if (in_valid && in_take)
				sent++;
			if (!in_valid || in_take) begin
				if (sent < ITEMS_PER_TEST && next_rand() % 4 != 0) begin
					rs1 = {next_rand(), next_rand()};
					in_valid <= 1'b1;
					in_pc <= {next_rand(), next_rand() & 32'hffff_fffc};
					in_instr <= make_instr(test_id);
					in_rs1_data <= rs1;
					// equal operands now and then so compares see both outcomes
					in_rs2_data <= (next_rand() % 4 == 0) ? rs1 : {next_rand(), next_rand()};
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
			report_problem("accepted items never came out of the DUT");
		$display("test %s: %0d items, %0d mismatches", name, sent, errors - errors_before);
		if (errors == errors_before)
			tests_passed++;
		else
			tests_failed++;
	endtask

	initial begin
		in_valid = 1'b0;
		in_pc = '0;
		in_instr = '0;
		in_rs1_data = '0;
		in_rs2_data = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		run_test(0, "reg_reg");
		run_test(1, "word_ops");
		run_test(2, "imm_lui");
		run_test(3, "branch");
		run_test(4, "mixed_unsupported");
		repeat (4) @(posedge clk);
		$display("%0d items checked, %0d tests passed, %0d tests failed", checked,
			tests_passed, tests_failed);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/exec_pkg.sv
logic/alu_core.sv
logic/issue_decode.sv
logic/execute_stage.sv
logic/exec_top.sv
test/exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator and run, success only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --assert -f vlog.f --top-module exec_tb -o exec_sim &&
./obj_dir/exec_sim | tee /dev/stderr | grep "All checks passed" > /dev/null ||
{ echo "simulation failed"; exit 1; }
